// ==== flist.f ====
+incdir+src
src/dsp_uop_pkg.sv
src/dsp_stage_pkg.sv
src/dsp_credit_fifo.sv
src/dsp_slot_select.sv
src/dsp_credit_tracker.sv
src/dsp_top.sv
testbench/dsp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the dispatch stage testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module dsp_tb -o dsp_sim; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/dsp_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "all tests passed" <<< "$out"; then
	exit 0
fi
exit 1

// ==== src/dsp_consts.svh ====
// sizing constants for the dispatch stage
// include this before any package or module that sizes ports or arrays from them

`ifndef DSP_CONSTS_SVH
`define DSP_CONSTS_SVH

// ==================================================
// group and port geometry
// ==================================================

// micro-op lanes carried by one rename group
`define DSP_MWIDTH 4

// reservation-station ports: alu0, alu1, muldiv, branch, mem
`define DSP_NPORTS 5

// ==================================================
// buffer sizes
// ==================================================

// reorder-buffer entries, kept a power of two so the index wraps by itself
`define DSP_ROB_ENTRIES 32

// groups held in the input queue, also the upstream credit count after reset
`define DSP_QUEUE_DEPTH 4

// entries per reservation station, also the initial downstream credit count
`define DSP_RS_DEPTH 4

`endif

// ==== src/dsp_credit_fifo.sv ====
// circular queue of any payload type with credit return to the sender
// the sender starts with DEPTH credits and spends one per write
// credit_o pulses one cycle after each pop to hand a credit back

module dsp_credit_fifo #(
	parameter type PAYLOAD_T = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_valid_i,
	input  PAYLOAD_T wr_data_i,
	input  logic     pop_i,
	output logic     rd_valid_o,
	output PAYLOAD_T rd_data_o,
	output logic     credit_o
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	PAYLOAD_T       mem [DEPTH];
	logic [PW-1:0]  wr_ptr_q;
	logic [PW-1:0]  rd_ptr_q;
	logic [CW-1:0]  count_q;
	logic           do_pop;

	// pointer step with wrap for any depth
	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
		return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// head is visible as soon as the write edge has passed
	assign rd_valid_o = (count_q != '0);
	assign rd_data_o  = mem[rd_ptr_q];
	assign do_pop     = pop_i && rd_valid_o;

	// storage array
	always_ff @(posedge clk) begin
		if (wr_valid_i)
			mem[wr_ptr_q] <= wr_data_i;
	end

	// pointers, occupancy and the credit pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_o <= 1'b0;
		end else begin
			if (wr_valid_i)
				wr_ptr_q <= ptr_next(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= ptr_next(rd_ptr_q);
			case ({wr_valid_i, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			credit_o <= do_pop;
		end
	end

	// sender must hold a credit, so a full queue never sees a write
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		wr_valid_i |-> (count_q < CW'(DEPTH)));

	// consumer only pops a head it can see
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop_i |-> rd_valid_o);

endmodule

// ==== src/dsp_credit_tracker.sv ====
// downstream credit counters, one per reservation-station port
// a port is available while its counter is above zero

`include "dsp_consts.svh"

module dsp_credit_tracker
	import dsp_stage_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  port_mask_t issue_i,
	input  port_mask_t credit_i,
	output port_mask_t avail_o
);

	localparam int             CW   = $clog2(`DSP_RS_DEPTH + 1);
	localparam logic [CW-1:0]  FULL = CW'(`DSP_RS_DEPTH);

	// ==================================================
	// per-port counters
	// ==================================================

	for (genvar p = 0; p < `DSP_NPORTS; p++) begin : g_port
		logic [CW-1:0] cnt_q;

		// issue spends a credit, a freed station entry returns one
		// both in the same cycle leave the count alone
		always_ff @(posedge clk) begin
			if (rst) begin
				cnt_q <= FULL;
			end else begin
				case ({issue_i[p], credit_i[p]})
					2'b10:   cnt_q <= cnt_q - 1'b1;
					2'b01:   cnt_q <= cnt_q + 1'b1;
					default: cnt_q <= cnt_q;
				endcase
			end
		end

		assign avail_o[p] = (cnt_q != '0);

		// selector never issues into an empty station
		a_no_underflow: assert property (@(posedge clk) disable iff (rst)
			(issue_i[p] && !credit_i[p]) |-> (cnt_q != '0));

		// station never frees more entries than it was given
		a_no_overflow: assert property (@(posedge clk) disable iff (rst)
			(credit_i[p] && !issue_i[p]) |-> (cnt_q != FULL));
	end

endmodule

// ==== src/dsp_slot_select.sv ====
// dispatch decision for the group at the head of the queue
// routes each valid lane to a free reservation-station port, numbers lanes
// into the reorder buffer and retries blocked lanes in later cycles

`include "dsp_consts.svh"

module dsp_slot_select
	import dsp_uop_pkg::*;
	import dsp_stage_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          head_valid_i,
	input  pipeline_group_t               head_group_i,
	input  port_mask_t                    port_avail_i,
	output logic                          head_pop_o,
	output port_mask_t                    port_issue_o,
	output rs_entry_t [`DSP_NPORTS-1:0]   rs_o
);

	// lanes of the current head already sent in earlier cycles
	logic [`DSP_MWIDTH-1:0]      done_q;
	// lanes sent this cycle
	logic [`DSP_MWIDTH-1:0]      lane_issue;
	logic [`DSP_MWIDTH-1:0]      lane_valid;
	// reorder index of the first valid lane in the head group
	rob_ndx_t                    rob_tail_q;
	rob_ndx_t                    valid_cnt;
	port_mask_t                  taken;
	rs_entry_t [`DSP_NPORTS-1:0] rs_d;
	logic                        group_done;

	// ==================================================
	// helpers
	// ==================================================

	// one-hot port for a class out of the ports still free, zero if none
	function automatic port_mask_t lane_grant(input op_class_e cls, input port_mask_t free);
		port_mask_t g;
		g = '0;
		case (cls)
			// alu prefers port 0 and spills to port 1
			CLS_ALU: begin
				if (free[PORT_ALU0])
					g[PORT_ALU0] = 1'b1;
				else if (free[PORT_ALU1])
					g[PORT_ALU1] = 1'b1;
			end
			CLS_MULDIV: g[PORT_MULDIV] = free[PORT_MULDIV];
			CLS_BRANCH: g[PORT_BRANCH] = free[PORT_BRANCH];
			default:    g[PORT_MEM]    = free[PORT_MEM];
		endcase
		return g;
	endfunction

	// build a station entry, squashing predicated-off ops to a ready nop
	function automatic rs_entry_t make_entry(input renamed_uop_t u, input rob_ndx_t ndx);
		rs_entry_t e;
		e.valid     = 1'b1;
		e.rob_ndx   = ndx;
		e.dst_preg  = u.dst_preg;
		e.src1_preg = u.src1_preg;
		e.src2_preg = u.src2_preg;
		if (u.pred) begin
			e.opcode   = u.opcode;
			e.src1_rdy = u.src1_rdy;
			e.src2_rdy = u.src2_rdy;
			e.imm      = u.imm;
		end else begin
			// nop still holds its reorder slot and must not wait on operands
			e.opcode   = OP_NOP;
			e.src1_rdy = 1'b1;
			e.src2_rdy = 1'b1;
			e.imm      = '0;
		end
		return e;
	endfunction

	// ==================================================
	// per-cycle lane scan
	// ==================================================

	always_comb begin
		port_mask_t grant;
		rob_ndx_t   lane_ndx;
		taken      = '0;
		lane_issue = '0;
		lane_valid = '0;
		valid_cnt  = '0;
		rs_d       = '0;
		// lane order gives both the port priority and the reorder numbering
		for (int l = 0; l < `DSP_MWIDTH; l++) begin
			lane_valid[l] = head_group_i.uop[l].valid;
			// index counts every valid lane, sent or not, so retries keep their slot
			lane_ndx = rob_tail_q + valid_cnt;
			grant    = '0;
			if (head_valid_i && lane_valid[l] && !done_q[l])
				grant = lane_grant(head_group_i.uop[l].cls, port_avail_i & ~taken);
			for (int p = 0; p < `DSP_NPORTS; p++) begin
				if (grant[p])
					rs_d[p] = make_entry(head_group_i.uop[l], lane_ndx);
			end
			lane_issue[l] = |grant;
			taken         = taken | grant;
			if (lane_valid[l])
				valid_cnt = valid_cnt + 1'b1;
		end
	end

	// group leaves once no valid lane is left pending
	assign group_done   = head_valid_i && ((lane_valid & ~done_q & ~lane_issue) == '0);
	assign head_pop_o   = group_done;
	assign port_issue_o = taken;

	// done mask and reorder tail
	always_ff @(posedge clk) begin
		if (rst) begin
			done_q     <= '0;
			rob_tail_q <= '0;
		end else if (group_done) begin
			done_q     <= '0;
			rob_tail_q <= rob_tail_q + valid_cnt;
		end else if (head_valid_i) begin
			done_q <= done_q | lane_issue;
		end
	end

	// station outputs, one cycle after the decision
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int p = 0; p < `DSP_NPORTS; p++)
				rs_o[p].valid <= 1'b0;
		end else begin
			rs_o <= rs_d;
		end
	end

	// done mask only refers to a head that holds still until its pop
	a_head_stable: assert property (@(posedge clk) disable iff (rst)
		(head_valid_i && !head_pop_o) |=> (head_valid_i && $stable(head_group_i)));

endmodule

// ==== src/dsp_stage_pkg.sv ====
// stage-level types for the dispatch path
// groups coming from rename, entries going to the reservation stations, port masks

`include "dsp_consts.svh"

package dsp_stage_pkg;
	import dsp_uop_pkg::*;

	// whole rename group, the unit held in the input queue
	typedef struct packed {
		// sequence tag travels with the group for debug
		logic [7:0]                       seq;
		renamed_uop_t [`DSP_MWIDTH-1:0]   uop;
	} pipeline_group_t;

	// one entry written into a reservation station
	typedef struct packed {
		logic     valid;
		rob_ndx_t rob_ndx;
		opcode_t  opcode;
		preg_t    dst_preg;
		preg_t    src1_preg;
		logic     src1_rdy;
		preg_t    src2_preg;
		logic     src2_rdy;
		imm_t     imm;
	} rs_entry_t;

	// one bit per reservation-station port
	typedef logic [`DSP_NPORTS-1:0] port_mask_t;

	// ==================================================
	// port numbering
	// ==================================================

	localparam int PORT_ALU0   = 0;
	localparam int PORT_ALU1   = 1;
	localparam int PORT_MULDIV = 2;
	localparam int PORT_BRANCH = 3;
	localparam int PORT_MEM    = 4;

endpackage

// ==== src/dsp_top.sv ====
// dispatch stage top level
// rename groups enter a credit queue, the selector drains the head into the
// reservation-station ports and the tracker gates ports by downstream credit

`include "dsp_consts.svh"

module dsp_top
	import dsp_stage_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	// upstream link from rename
	input  logic                          group_valid_i,
	input  pipeline_group_t               group_i,
	output logic                          group_credit_o,
	// downstream links to the reservation stations
	output rs_entry_t [`DSP_NPORTS-1:0]   rs_o,
	input  port_mask_t                    rs_credit_i
);

	logic            head_valid;
	pipeline_group_t head_group;
	logic            head_pop;
	port_mask_t      port_avail;
	port_mask_t      port_issue;

	// ==================================================
	// group queue
	// ==================================================

	dsp_credit_fifo #(
		.PAYLOAD_T (pipeline_group_t),
		.DEPTH     (`DSP_QUEUE_DEPTH)
	) u_queue (
		.clk        (clk),
		.rst        (rst),
		.wr_valid_i (group_valid_i),
		.wr_data_i  (group_i),
		.pop_i      (head_pop),
		.rd_valid_o (head_valid),
		.rd_data_o  (head_group),
		.credit_o   (group_credit_o)
	);

	// ==================================================
	// slot selection and downstream credits
	// ==================================================

	dsp_slot_select u_select (
		.clk          (clk),
		.rst          (rst),
		.head_valid_i (head_valid),
		.head_group_i (head_group),
		.port_avail_i (port_avail),
		.head_pop_o   (head_pop),
		.port_issue_o (port_issue),
		.rs_o         (rs_o)
	);

	// counters move on the edge that also registers rs_o
	dsp_credit_tracker u_credit (
		.clk      (clk),
		.rst      (rst),
		.issue_i  (port_issue),
		.credit_i (rs_credit_i),
		.avail_o  (port_avail)
	);

endmodule

// ==== src/dsp_uop_pkg.sv ====
// per micro-op types shared by rename and dispatch
// covers op classes, register and reorder index widths and the renamed uop

`include "dsp_consts.svh"

package dsp_uop_pkg;

	// ==================================================
	// op classes and field types
	// ==================================================

	// class picks the reservation-station port family
	typedef enum logic [1:0] {
		CLS_ALU    = 2'd0,
		CLS_MULDIV = 2'd1,
		CLS_BRANCH = 2'd2,
		CLS_MEM    = 2'd3
	} op_class_e;

	typedef logic [4:0] areg_t;
	typedef logic [5:0] preg_t;
	typedef logic [7:0] opcode_t;
	typedef logic [15:0] imm_t;

	// reorder index wide enough for the whole reorder buffer
	typedef logic [$clog2(`DSP_ROB_ENTRIES)-1:0] rob_ndx_t;

	// opcode sent in place of a predicated-off op
	localparam opcode_t OP_NOP = 8'h00;

	// ==================================================
	// renamed micro-op as it leaves rename
	// ==================================================

	typedef struct packed {
		logic      valid;
		// predicate false means the op is squashed to a nop
		logic      pred;
		op_class_e cls;
		opcode_t   opcode;
		areg_t     dst_areg;
		preg_t     dst_preg;
		// sources carry the ready bit from the rename scoreboard
		preg_t     src1_preg;
		logic      src1_rdy;
		preg_t     src2_preg;
		logic      src2_rdy;
		imm_t      imm;
	} renamed_uop_t;

endpackage

// ==== testbench/dsp_stimulus.txt ====
// one lane per line, four lines per group, all fields hex
// valid pred cls opcode dst_areg dst_preg src1 src1_rdy src2 src2_rdy imm ports
1 1 0 11 01 21 02 1 03 0 0010 03
1 1 0 12 02 22 04 0 05 1 0020 03
1 1 0 13 03 23 06 1 07 1 0030 03
1 1 0 14 04 24 08 0 09 0 0040 03
1 1 0 15 05 25 0a 1 0b 1 0050 03
1 1 1 31 06 26 0c 0 0d 0 0000 04
1 1 2 41 07 27 0e 1 0f 0 0ffc 08
1 1 3 51 08 28 10 1 11 1 0100 10
1 1 1 32 09 29 12 0 13 1 0000 04
1 1 1 33 0a 2a 14 1 15 0 0000 04
1 0 0 16 0b 2b 16 0 17 0 1234 03
0 0 0 00 00 00 00 0 00 0 0000 00
1 1 3 52 0c 2c 18 1 19 0 0008 10
1 1 3 53 0d 2d 1a 0 1b 1 0010 10
1 1 3 52 0e 2e 1c 1 1d 1 fff0 10
1 0 0 17 0f 2f 1e 0 1f 1 0abc 03
1 1 2 42 10 30 20 1 21 1 0040 08
0 1 1 34 11 31 22 1 23 1 5555 00
1 1 0 18 12 32 24 0 25 0 0007 03
1 0 2 43 13 33 26 0 27 0 fe00 08
1 1 0 19 14 34 28 1 29 1 0001 03
1 0 0 1a 15 35 2a 0 2b 0 00ff 03
1 1 3 53 16 36 2c 1 2d 0 0020 10
1 1 1 35 17 37 2e 0 2f 1 0000 04
0 0 3 00 00 00 00 0 00 0 0000 00
1 1 3 54 18 38 30 1 31 0 0030 10
1 1 2 44 19 39 32 0 33 1 0002 08
1 1 0 1b 1a 3a 34 1 35 1 7fff 03

// ==== testbench/dsp_tb.sv ====
// testbench for the dispatch stage top level
// loads rename groups from the stimulus file, sends them twice under upstream credit,
// models the reservation stations with random credit return and checks every entry

`include "dsp_consts.svh"

module dsp_tb
	import dsp_uop_pkg::*;
	import dsp_stage_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYC  = 8;
	localparam int NFILE      = 7;
	// second pass pushes the reorder numbering past its wrap
	localparam int NGROUPS    = 2 * NFILE;
	localparam int NFIELDS    = 12;
	localparam int NWORDS     = NFILE * `DSP_MWIDTH * NFIELDS;
	localparam int WATCHDOG_T = (RESET_CYC + NGROUPS * `DSP_MWIDTH * 20) * CLK_PERIOD;
	// window of cycles after reset in which the stations free nothing
	localparam int STALL_FROM = 12;
	localparam int STALL_TO   = 42;
	localparam int NTESTS     = 6;

	// expected entry tagged with the predicate and allowed ports of its lane
	typedef struct packed {
		logic       pred;
		port_mask_t ports;
		rs_entry_t  e;
	} exp_t;

	logic                        clk;
	logic                        rst;
	logic                        group_valid_i;
	pipeline_group_t             group_i;
	logic                        group_credit_o;
	rs_entry_t [`DSP_NPORTS-1:0] rs_o;
	port_mask_t                  rs_credit_i;

	logic [15:0]     stim_mem [NWORDS];
	pipeline_group_t groups [NGROUPS];
	// expected entries per class, alu shared by ports 0 and 1
	exp_t            q_alu[$];
	exp_t            q_mul[$];
	exp_t            q_br[$];
	exp_t            q_mem[$];
	int              test_err [NTESTS];
	int              outstanding [`DSP_NPORTS];
	int              total_valid;
	int              seen;
	int              sent;
	int              credits_up;
	int              credit_pulses;
	int              cyc;

	dsp_top uut (
		.clk            (clk),
		.rst            (rst),
		.group_valid_i  (group_valid_i),
		.group_i        (group_i),
		.group_credit_o (group_credit_o),
		.rs_o           (rs_o),
		.rs_credit_i    (rs_credit_i)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==================================================
	// reference rules
	// ==================================================

	// predicated-off lane turns into a ready nop with no immediate
	function automatic rs_entry_t expected_entry(input renamed_uop_t u, input rob_ndx_t ndx);
		rs_entry_t e;
		e.valid     = 1'b1;
		e.rob_ndx   = ndx;
		e.opcode    = u.pred ? u.opcode : OP_NOP;
		e.dst_preg  = u.dst_preg;
		e.src1_preg = u.src1_preg;
		e.src1_rdy  = u.pred ? u.src1_rdy : 1'b1;
		e.src2_preg = u.src2_preg;
		e.src2_rdy  = u.pred ? u.src2_rdy : 1'b1;
		e.imm       = u.pred ? u.imm : 16'h0000;
		return e;
	endfunction

	function automatic port_mask_t valid_bits(input rs_entry_t [`DSP_NPORTS-1:0] r);
		port_mask_t m;
		for (int p = 0; p < `DSP_NPORTS; p++)
			m[p] = r[p].valid;
		return m;
	endfunction

	task automatic check_mask(input int t, input string what, input port_mask_t exp,
			input port_mask_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t: %s expected %b got %b", $time, what, exp, act);
			test_err[t]++;
		end
	endtask

	task automatic check_entry(input int t, input int p, input rs_entry_t exp,
			input rs_entry_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t: port %0d rob %0d expected %h got rob %0d %h",
				$time, p, exp.rob_ndx, exp, act.rob_ndx, act);
			test_err[t]++;
		end
	endtask

	// unpack the file into groups and number valid lanes in send order
	task automatic build_stimulus();
		renamed_uop_t u;
		exp_t         x;
		int           b;
		int           rob_cnt;
		rob_cnt     = 0;
		total_valid = 0;
		for (int g = 0; g < NGROUPS; g++) begin
			groups[g].seq = 8'(g);
			for (int l = 0; l < `DSP_MWIDTH; l++) begin
				b = ((g % NFILE) * `DSP_MWIDTH + l) * NFIELDS;
				u.valid     = stim_mem[b][0];
				u.pred      = stim_mem[b+1][0];
				u.cls       = op_class_e'(stim_mem[b+2][1:0]);
				u.opcode    = stim_mem[b+3][7:0];
				u.dst_areg  = stim_mem[b+4][4:0];
				u.dst_preg  = stim_mem[b+5][5:0];
				u.src1_preg = stim_mem[b+6][5:0];
				u.src1_rdy  = stim_mem[b+7][0];
				u.src2_preg = stim_mem[b+8][5:0];
				u.src2_rdy  = stim_mem[b+9][0];
				u.imm       = stim_mem[b+10];
				groups[g].uop[l] = u;
				if (u.valid) begin
					x.pred  = u.pred;
					// allowed ports come straight from the file
					x.ports = stim_mem[b+11][4:0];
					x.e     = expected_entry(u, rob_ndx_t'(rob_cnt % `DSP_ROB_ENTRIES));
					case (u.cls)
						CLS_ALU:    q_alu.push_back(x);
						CLS_MULDIV: q_mul.push_back(x);
						CLS_BRANCH: q_br.push_back(x);
						default:    q_mem.push_back(x);
					endcase
					rob_cnt++;
					total_valid++;
				end
			end
		end
	endtask

	// oldest pending lane of any class whose reorder index matches
	// only class heads are looked at so each class must arrive in order
	task automatic take_expected(input rob_ndx_t ndx, output exp_t x, output bit found);
		found = 1'b0;
		x     = '0;
		if (q_alu.size() > 0 && q_alu[0].e.rob_ndx == ndx) begin
			x     = q_alu.pop_front();
			found = 1'b1;
		end else if (q_mul.size() > 0 && q_mul[0].e.rob_ndx == ndx) begin
			x     = q_mul.pop_front();
			found = 1'b1;
		end else if (q_br.size() > 0 && q_br[0].e.rob_ndx == ndx) begin
			x     = q_br.pop_front();
			found = 1'b1;
		end else if (q_mem.size() > 0 && q_mem[0].e.rob_ndx == ndx) begin
			x     = q_mem.pop_front();
			found = 1'b1;
		end
	endtask

	task automatic report_test(input int t, input string name);
		if (test_err[t] == 0)
			$display("test %0d %s: ok", t, name);
		else
			$display("test %0d %s: %0d errors", t, name, test_err[t]);
	endtask

	// ==================================================
	// falling-edge sender, monitor and station model
	// ==================================================

	always @(negedge clk) begin : station_side
		exp_t       x;
		bit         found;
		bit         stalled;
		port_mask_t credit_d;
		port_mask_t pbit;
		if (!rst) begin
			stalled = (cyc >= STALL_FROM) && (cyc < STALL_TO);
			// nothing may come out before the first group goes in
			if (cyc < 3) begin
				check_mask(0, "rs_o valid bits after reset", '0, valid_bits(rs_o));
				if (group_credit_o !== 1'b0) begin
					$display("[FAIL] %0t: group_credit_o high before any group", $time);
					test_err[0]++;
				end
			end
			// upstream side spends a credit per group and gets one back per pulse
			if (group_credit_o) begin
				credit_pulses++;
				credits_up++;
			end
			if (cyc >= 3 && sent < NGROUPS && credits_up > 0) begin
				group_valid_i <= 1'b1;
				group_i       <= groups[sent];
				sent++;
				credits_up--;
			end else begin
				group_valid_i <= 1'b0;
			end
			if (credits_up < 0 || credit_pulses > sent) begin
				$display("upstream credits out of step: %0d held, %0d returned, %0d sent",
					credits_up, credit_pulses, sent);
				test_err[5]++;
			end
			// entries written into the stations last edge
			for (int p = 0; p < `DSP_NPORTS; p++) begin
				if (rs_o[p].valid) begin
					outstanding[p]++;
					seen++;
					if (outstanding[p] > `DSP_RS_DEPTH) begin
						$display("port %0d holds %0d entries, more than its station depth",
							p, outstanding[p]);
						test_err[4]++;
					end
					take_expected(rs_o[p].rob_ndx, x, found);
					if (!found) begin
						$display("port %0d got reorder index %0d matching no pending lane",
							p, rs_o[p].rob_ndx);
						test_err[2]++;
					end else begin
						pbit = port_mask_t'(1) << p;
						check_mask(1, "issuing port among allowed ports", pbit,
							x.ports & pbit);
						check_entry(x.pred ? 2 : 3, p, x.e, rs_o[p]);
					end
				end
			end
			// stations free entries at random, except in the stall window
			credit_d = '0;
			for (int p = 0; p < `DSP_NPORTS; p++) begin
				if (!stalled && outstanding[p] > 0 && ($urandom % 3) == 0) begin
					credit_d[p] = 1'b1;
					outstanding[p]--;
				end
			end
			rs_credit_i <= credit_d;
			cyc++;
		end
	end

	// ==================================================
	// run control
	// ==================================================

	initial begin
		#(WATCHDOG_T);
		$display("timeout: the dispatch stage stopped delivering entries");
		$display("tests failed");
		$finish;
	end

	initial begin
		int nbad;
		clk           = 1'b0;
		rst           = 1'b1;
		group_valid_i = 1'b0;
		group_i       = '0;
		rs_credit_i   = '0;
		seen          = 0;
		sent          = 0;
		credits_up    = `DSP_QUEUE_DEPTH;
		credit_pulses = 0;
		cyc           = 0;
		for (int t = 0; t < NTESTS; t++)
			test_err[t] = 0;
		for (int p = 0; p < `DSP_NPORTS; p++)
			outstanding[p] = 0;
		void'($urandom(32'h78e7));
		$readmemh("testbench/dsp_stimulus.txt", stim_mem);
		build_stimulus();
		repeat (RESET_CYC) @(posedge clk);
		@(negedge clk);
		rst <= 1'b0;
		wait (seen >= total_valid && credit_pulses >= NGROUPS);
		// a few idle cycles so a duplicate entry still shows up
		repeat (4) @(negedge clk);
		if (q_alu.size() + q_mul.size() + q_br.size() + q_mem.size() != 0) begin
			$display("some lanes never arrived at any port");
			test_err[2]++;
		end
		if (credit_pulses != NGROUPS || credits_up != `DSP_QUEUE_DEPTH) begin
			$display("upstream got %0d credit pulses for %0d groups, holds %0d",
				credit_pulses, NGROUPS, credits_up);
			test_err[5]++;
		end
		report_test(0, "idle after reset");
		report_test(1, "port class map");
		report_test(2, "lane contents and reorder order");
		report_test(3, "predicated-off nops");
		report_test(4, "downstream back-pressure");
		report_test(5, "upstream credits");
		nbad = 0;
		for (int t = 0; t < NTESTS; t++) begin
			if (test_err[t] != 0)
				nbad++;
		end
		$display("summary: %0d tests run, %0d clean, %0d with errors",
			NTESTS, NTESTS - nbad, nbad);
		if (nbad == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
